/* Bender.yml */
package:
  name: red_offload_tile

dependencies: {}

sources:
  - red_pkg.sv
  - red_chan_port.sv
  - red_arbiter.sv
  - red_exec_unit.sv
  - red_offload_tile.sv
  - target: test
    files:
      - tb_red_offload_tile.sv

/* files.f */
red_pkg.sv
red_chan_port.sv
red_arbiter.sv
red_exec_unit.sv
red_offload_tile.sv
tb_red_offload_tile.sv

/* red_arbiter.sv */
//////////////////////////////
// Reduction arbiter
// Round-robin grant of the execution unit and
// tag based return of results to the channels
//////////////////////////////
module red_arbiter
  import red_pkg::*;
#(
  parameter  int unsigned NUM_CHAN = 2,
  localparam int unsigned IDX_W    = (NUM_CHAN > 1) ? $clog2(NUM_CHAN) : 1
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  exec_req_t [NUM_CHAN-1:0]   chan_req_i,
  input  logic      [NUM_CHAN-1:0]   chan_valid_i,
  output logic      [NUM_CHAN-1:0]   chan_ready_o,
  output exec_req_t                  exec_req_o,
  output logic      [IDX_W-1:0]      exec_tag_o,
  output logic                       exec_valid_o,
  input  logic                       exec_ready_i,
  input  data_t                      res_data_i,
  input  logic      [IDX_W-1:0]      res_tag_i,
  input  logic                       res_valid_i,
  output logic                       res_ready_o,
  output data_t     [NUM_CHAN-1:0]   chan_res_o,
  output logic      [NUM_CHAN-1:0]   chan_res_valid_o,
  input  logic      [NUM_CHAN-1:0]   chan_res_ready_i
);

  typedef logic [IDX_W-1:0] idx_t;

  idx_t                ptr_q;
  idx_t                rr_idx;
  idx_t                sel_idx;
  idx_t                lock_idx_q;
  logic                lock_q;
  logic                exec_fire;
  logic [NUM_CHAN-1:0] grant;

  //////////////////////////////
  // Request arbitration
  //////////////////////////////

  // First valid channel at or after the pointer
  always_comb begin
    int unsigned idx;
    logic        found;
    rr_idx = ptr_q;
    found  = 1'b0;
    for (int unsigned k = 0; k < NUM_CHAN; k++) begin
      idx = (ptr_q + k) % NUM_CHAN;
      if (!found && chan_valid_i[idx]) begin
        rr_idx = idx_t'(idx);
        found  = 1'b1;
      end
    end
  end

  // A stalled grant is held so the offered request stays put
  assign sel_idx      = lock_q ? lock_idx_q : rr_idx;
  assign exec_valid_o = chan_valid_i[sel_idx];
  assign exec_req_o   = chan_req_i[sel_idx];
  assign exec_tag_o   = sel_idx;
  assign exec_fire    = exec_valid_o & exec_ready_i;

  always_comb begin
    for (int unsigned i = 0; i < NUM_CHAN; i++) begin
      grant[i] = exec_valid_o && (sel_idx == idx_t'(i));
    end
  end

  assign chan_ready_o = grant & {NUM_CHAN{exec_ready_i}};

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ptr_q      <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      lock_q     <= exec_valid_o & ~exec_ready_i;
      lock_idx_q <= sel_idx;
      if (exec_fire) begin
        ptr_q <= (sel_idx == idx_t'(NUM_CHAN - 1)) ? '0 : sel_idx + 1'b1;
      end
    end
  end

  //////////////////////////////
  // Result steering
  //////////////////////////////

  always_comb begin
    for (int unsigned i = 0; i < NUM_CHAN; i++) begin
      chan_res_o[i]       = res_data_i;
      chan_res_valid_o[i] = res_valid_i && (res_tag_i == idx_t'(i));
    end
  end

  assign res_ready_o = chan_res_ready_i[res_tag_i];

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (|chan_valid_i) |-> $onehot(grant) && ((grant & chan_valid_i) == grant));

  // Tags come back from the unit, so a bad one means a lost result
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    res_valid_i |-> (int'(res_tag_i) < NUM_CHAN));

endmodule

/* red_chan_port.sv */
//////////////////////////////
// Reduction channel port
// One-entry request buffer that rewrites a channel
// request into the three-operand execution form
//////////////////////////////
module red_chan_port
  import red_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  red_req_t  req_i,
  input  logic      req_valid_i,
  output logic      req_ready_o,
  output exec_req_t exec_req_o,
  output logic      exec_valid_o,
  input  logic      exec_ready_i
);

  logic     run_q;
  logic     full_q;
  red_req_t buf_q;
  logic     accept;
  logic     leave;

  // Ready stays low until the first edge out of reset
  assign leave       = full_q & exec_ready_i;
  assign req_ready_o = run_q & (~full_q | exec_ready_i);
  assign accept      = req_valid_i & req_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      run_q  <= 1'b0;
      full_q <= 1'b0;
    end else begin
      run_q <= 1'b1;
      if (accept) begin
        full_q <= 1'b1;
      end else if (leave) begin
        full_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      buf_q <= req_i;
    end
  end

  // Operand slot layout per operation
  always_comb begin
    exec_req_o = '0;
    case (buf_q.op)
      RED_ADD: begin
        exec_req_o.op          = EXEC_ADD;
        exec_req_o.operands[1] = buf_q.op_a;
        exec_req_o.operands[2] = buf_q.op_b;
      end
      RED_MUL: begin
        exec_req_o.op          = EXEC_MUL;
        exec_req_o.operands[0] = buf_q.op_a;
        exec_req_o.operands[1] = buf_q.op_b;
      end
      default: begin
        exec_req_o.op          = EXEC_MINMAX;
        exec_req_o.min_mode    = (buf_q.op == RED_MIN);
        exec_req_o.operands[0] = buf_q.op_a;
        exec_req_o.operands[1] = buf_q.op_b;
      end
    endcase
  end

  assign exec_valid_o = full_q;

  // Offered request must not change while the arbiter stalls it
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    exec_valid_o && !exec_ready_i |=> exec_valid_o && $stable(exec_req_o));

endmodule

/* red_exec_unit.sv */
//////////////////////////////
// Reduction execution unit
// Pipelined signed integer add, multiply and min/max
// with a tag carried alongside each request
//////////////////////////////
module red_exec_unit
  import red_pkg::*;
#(
  parameter int unsigned TAG_W = 1
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  exec_req_t        req_i,
  input  logic [TAG_W-1:0] tag_i,
  input  logic             valid_i,
  output logic             ready_o,
  output data_t            res_o,
  output logic [TAG_W-1:0] tag_o,
  output logic             valid_o,
  input  logic             ready_i
);

  typedef logic [TAG_W-1:0] tag_t;

  logic      advance;
  logic      a_lt_b;
  data_t     exec_res;
  logic      s1_valid_q;
  exec_req_t s1_req_q;
  tag_t      s1_tag_q;
  logic      s2_valid_q;
  data_t     s2_res_q;
  tag_t      s2_tag_q;
  logic      out_valid_q;
  data_t     out_res_q;
  tag_t      out_tag_q;

  // Whole pipeline stalls on an unaccepted result
  assign advance = ~(out_valid_q & ~ready_i);
  assign ready_o = advance;

  //////////////////////////////
  // Execute
  //////////////////////////////

  assign a_lt_b = $signed(s1_req_q.operands[0]) < $signed(s1_req_q.operands[1]);

  always_comb begin
    exec_res = '0;
    case (s1_req_q.op)
      EXEC_ADD: exec_res = s1_req_q.operands[1] + s1_req_q.operands[2];
      // Low half of the product only
      EXEC_MUL: exec_res = s1_req_q.operands[0] * s1_req_q.operands[1];
      EXEC_MINMAX: begin
        if (s1_req_q.min_mode) begin
          exec_res = a_lt_b ? s1_req_q.operands[0] : s1_req_q.operands[1];
        end else begin
          exec_res = a_lt_b ? s1_req_q.operands[1] : s1_req_q.operands[0];
        end
      end
      default: exec_res = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      s1_valid_q  <= 1'b0;
      s2_valid_q  <= 1'b0;
      out_valid_q <= 1'b0;
    end else if (advance) begin
      s1_valid_q  <= valid_i;
      s2_valid_q  <= s1_valid_q;
      out_valid_q <= s2_valid_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (advance) begin
      s1_req_q  <= req_i;
      s1_tag_q  <= tag_i;
      s2_res_q  <= exec_res;
      s2_tag_q  <= s1_tag_q;
      out_res_q <= s2_res_q;
      out_tag_q <= s2_tag_q;
    end
  end

  assign res_o   = out_res_q;
  assign tag_o   = out_tag_q;
  assign valid_o = out_valid_q;

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_o && !ready_i |=> valid_o && $stable(res_o) && $stable(tag_o));

endmodule

/* red_offload_tile.sv */
//////////////////////////////
// Reduction offload tile
// Channel ports sharing one execution unit
// through a round-robin arbiter
//////////////////////////////
module red_offload_tile
  import red_pkg::*;
#(
  parameter  int unsigned NUM_CHAN = 2,
  localparam int unsigned IDX_W    = (NUM_CHAN > 1) ? $clog2(NUM_CHAN) : 1
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  red_req_t [NUM_CHAN-1:0]  req_i,
  input  logic     [NUM_CHAN-1:0]  req_valid_i,
  output logic     [NUM_CHAN-1:0]  req_ready_o,
  output data_t    [NUM_CHAN-1:0]  res_o,
  output logic     [NUM_CHAN-1:0]  res_valid_o,
  input  logic     [NUM_CHAN-1:0]  res_ready_i
);

  exec_req_t [NUM_CHAN-1:0] chan_req;
  logic      [NUM_CHAN-1:0] chan_valid;
  logic      [NUM_CHAN-1:0] chan_ready;
  exec_req_t                exec_req;
  logic      [IDX_W-1:0]    exec_tag;
  logic                     exec_valid;
  logic                     exec_ready;
  data_t                    res_data;
  logic      [IDX_W-1:0]    res_tag;
  logic                     res_valid;
  logic                     res_ready;

  for (genvar i = 0; i < NUM_CHAN; i++) begin : gen_chan
    red_chan_port i_chan_port (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .req_i        (req_i[i]),
      .req_valid_i  (req_valid_i[i]),
      .req_ready_o  (req_ready_o[i]),
      .exec_req_o   (chan_req[i]),
      .exec_valid_o (chan_valid[i]),
      .exec_ready_i (chan_ready[i])
    );
  end

  red_arbiter #(
    .NUM_CHAN (NUM_CHAN)
  ) i_arbiter (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .chan_req_i       (chan_req),
    .chan_valid_i     (chan_valid),
    .chan_ready_o     (chan_ready),
    .exec_req_o       (exec_req),
    .exec_tag_o       (exec_tag),
    .exec_valid_o     (exec_valid),
    .exec_ready_i     (exec_ready),
    .res_data_i       (res_data),
    .res_tag_i        (res_tag),
    .res_valid_i      (res_valid),
    .res_ready_o      (res_ready),
    .chan_res_o       (res_o),
    .chan_res_valid_o (res_valid_o),
    .chan_res_ready_i (res_ready_i)
  );

  red_exec_unit #(
    .TAG_W (IDX_W)
  ) i_exec_unit (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (exec_req),
    .tag_i   (exec_tag),
    .valid_i (exec_valid),
    .ready_o (exec_ready),
    .res_o   (res_data),
    .tag_o   (res_tag),
    .valid_o (res_valid),
    .ready_i (res_ready)
  );

endmodule

/* red_pkg.sv */
//////////////////////////////
// Reduction offload package
// Operand word, operation encodings and the
// request structs shared by the offload blocks
//////////////////////////////
package red_pkg;

  localparam int unsigned DATA_W = 32;

  // Signed operand and result word
  typedef logic signed [DATA_W-1:0] data_t;

  // Reduction operation as issued by a channel
  typedef enum logic [1:0] {
    RED_ADD = 2'd0,
    RED_MUL = 2'd1,
    RED_MAX = 2'd2,
    RED_MIN = 2'd3
  } red_op_e;

  // Opcode of the shared execution unit
  typedef enum logic [1:0] {
    EXEC_ADD    = 2'd0,
    EXEC_MUL    = 2'd1,
    EXEC_MINMAX = 2'd2
  } exec_op_e;

  // Channel request, operation plus two operands
  typedef struct packed {
    red_op_e op;
    data_t   op_a;
    data_t   op_b;
  } red_req_t;

  // Three operand form for the execution unit
  // min_mode high selects min, low selects max
  typedef struct packed {
    exec_op_e    op;
    logic        min_mode;
    data_t [2:0] operands;
  } exec_req_t;

endpackage

/* tb_red_offload_tile.sv */
//////////////////////////////
// Reduction offload tile testbench
// Random requests on two channels, checked by
// assertions against queues of expected results
//////////////////////////////
module tb_red_offload_tile
  import red_pkg::*;
();

  localparam int unsigned NUM_CHAN = 2;
  localparam int N_IDLE = 40;
  localparam int N_FAIR = 40;
  localparam int N_BP   = 60;
  // Rough cycles per request in each phase, then a wide margin
  localparam int TEST_CYCLES    = 6 * N_IDLE + 2 * N_FAIR + 4 * N_BP + 40;
  localparam int TIMEOUT_CYCLES = TEST_CYCLES * 10 / 3;

  logic                    clk_i;
  logic                    rst_n_i;
  red_req_t [NUM_CHAN-1:0] req_i       = '0;
  logic     [NUM_CHAN-1:0] req_valid_i = '0;
  logic     [NUM_CHAN-1:0] req_ready_o;
  data_t    [NUM_CHAN-1:0] res_o;
  logic     [NUM_CHAN-1:0] res_valid_o;
  logic     [NUM_CHAN-1:0] res_ready_i = '1;

  integer     seed = 72;
  red_req_t   pend_q [NUM_CHAN][$];
  data_t      exp_q [NUM_CHAN][$];
  data_t      exp_head [NUM_CHAN];
  int         exp_cnt [NUM_CHAN] = '{default: 0};
  int         sent_cnt [NUM_CHAN] = '{default: 0};
  int         res_cnt [NUM_CHAN] = '{default: 0};
  logic       accepted [NUM_CHAN] = '{default: 1'b0};
  logic [1:0] last_res_chan = 2'd2;
  logic       idle_mode = 1'b0;
  logic       fair_mode = 1'b0;
  logic       bp_mode = 1'b0;
  int         stall_left = 0;
  int         cycle_cnt = 0;

  red_offload_tile #(
    .NUM_CHAN (NUM_CHAN)
  ) red_offload_tile_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (req_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .res_o       (res_o),
    .res_valid_o (res_valid_o),
    .res_ready_i (res_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic report_failure(string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  // Mostly random, sometimes an extreme or tiny value
  function automatic data_t pick_operand();
    logic [31:0] r;
    r = $random(seed);
    case (r[2:0])
      3'd0: return 32'sh7fff_ffff;
      3'd1: return 32'sh8000_0000;
      3'd2: return -32'sd1;
      3'd3: return {{29{r[31]}}, r[31:29]};
      default: return $random(seed);
    endcase
  endfunction

  function automatic red_op_e random_op();
    logic [1:0] r;
    r = $random(seed);
    return red_op_e'(r);
  endfunction

  function automatic red_req_t make_req(red_op_e op);
    red_req_t req;
    req.op   = op;
    req.op_a = pick_operand();
    req.op_b = pick_operand();
    return req;
  endfunction

  // Reference result of one request
  function automatic data_t expect_result(red_req_t req);
    case (req.op)
      RED_ADD: return req.op_a + req.op_b;
      RED_MUL: return req.op_a * req.op_b;
      RED_MAX: return (req.op_a > req.op_b) ? req.op_a : req.op_b;
      default: return (req.op_a < req.op_b) ? req.op_a : req.op_b;
    endcase
  endfunction

  task automatic send_req(int ch, red_req_t req);
    pend_q[ch].push_back(req);
    sent_cnt[ch]++;
  endtask

  function automatic logic all_done();
    logic done;
    done = 1'b1;
    for (int c = 0; c < NUM_CHAN; c++) begin
      done &= (res_cnt[c] == sent_cnt[c]);
    end
    return done;
  endfunction

  task automatic wait_drain();
    @(negedge clk_i);
    while (!all_done()) begin
      @(negedge clk_i);
    end
  endtask

  //////////////////////////////
  // Drivers and scoreboard
  //////////////////////////////

  always @(negedge clk_i) begin
    for (int c = 0; c < NUM_CHAN; c++) begin
      if (!req_valid_i[c] || accepted[c]) begin
        if (pend_q[c].size() != 0) begin
          req_i[c]       = pend_q[c].pop_front();
          req_valid_i[c] = 1'b1;
        end else begin
          req_valid_i[c] = 1'b0;
        end
      end
    end
  end

  // Random stalls of 2 to 9 cycles on channel 0 results
  always @(negedge clk_i) begin
    logic [31:0] r;
    if (!bp_mode) begin
      res_ready_i[0] = 1'b1;
    end else if (stall_left > 0) begin
      stall_left--;
      res_ready_i[0] = 1'b0;
    end else begin
      r = $random(seed);
      if (r[1:0] == 2'd0) begin
        stall_left     = 1 + int'(r[4:2]);
        res_ready_i[0] = 1'b0;
      end else begin
        res_ready_i[0] = 1'b1;
      end
    end
  end

  always @(posedge clk_i) begin
    for (int c = 0; c < NUM_CHAN; c++) begin
      accepted[c] = req_valid_i[c] && req_ready_o[c];
      if (accepted[c]) begin
        exp_q[c].push_back(expect_result(req_i[c]));
      end
      if (res_valid_o[c] && res_ready_i[c]) begin
        if (exp_q[c].size() != 0) begin
          void'(exp_q[c].pop_front());
        end
        res_cnt[c]++;
        last_res_chan = 2'(c);
      end
      exp_cnt[c]  = exp_q[c].size();
      exp_head[c] = (exp_cnt[c] != 0) ? exp_q[c][0] : '0;
    end
    if (!fair_mode) begin
      last_res_chan = 2'd2;
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      report_failure($sformatf("Timeout after %0d cycles, results still missing", cycle_cnt));
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  assert property (@(posedge clk_i) (!rst_n_i || $rose(rst_n_i)) |-> req_ready_o == '0)
    else report_failure($sformatf("Mismatch req_ready_o in reset: expected 0x0, got 0x%0h",
                                  $sampled(req_ready_o)));

  assert property (@(posedge clk_i) (!rst_n_i || $rose(rst_n_i)) |-> res_valid_o == '0)
    else report_failure($sformatf("Mismatch res_valid_o in reset: expected 0x0, got 0x%0h",
                                  $sampled(res_valid_o)));

  for (genvar c = 0; c < NUM_CHAN; c++) begin : gen_check
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      res_valid_o[c] && res_ready_i[c] && exp_cnt[c] != 0 |-> res_o[c] == exp_head[c])
      else report_failure($sformatf("Mismatch res_o[%0d]: expected 0x%08h, got 0x%08h",
                                    c, $sampled(exp_head[c]), $sampled(res_o[c])));

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      res_valid_o[c] && res_ready_i[c] |-> exp_cnt[c] != 0)
      else report_failure($sformatf("Channel %0d returned a result nobody asked for", c));

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      res_valid_o[c] && !res_ready_i[c] |=> res_valid_o[c] && $stable(res_o[c]))
      else report_failure($sformatf("Channel %0d result dropped or changed while stalled", c));

    // Valid rises on the third edge, so it is first seen at the fourth
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      idle_mode && req_valid_i[c] && req_ready_o[c] |->
        ##1 !res_valid_o[c] ##1 !res_valid_o[c] ##1 !res_valid_o[c] ##1 res_valid_o[c])
      else report_failure($sformatf("Channel %0d result not valid 3 edges after its request", c));

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      fair_mode && res_valid_o[c] && res_ready_i[c] |-> last_res_chan != c)
      else report_failure($sformatf("Channel %0d got two results in a row under contention", c));
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  initial begin
    rst_n_i = 1'b1;
    // Falls before the first edge so the async clear is seen
    #1 rst_n_i = 1'b0;
    repeat (10) @(negedge clk_i);
    rst_n_i = 1'b1;

    // One request in flight, every op on both channels
    idle_mode = 1'b1;
    for (int i = 0; i < N_IDLE; i++) begin
      @(posedge clk_i);
      send_req((i / 4) % NUM_CHAN, make_req(red_op_e'(i % 4)));
      wait_drain();
    end
    idle_mode = 1'b0;

    fair_mode = 1'b1;
    @(posedge clk_i);
    for (int i = 0; i < N_FAIR; i++) begin
      for (int c = 0; c < NUM_CHAN; c++) begin
        send_req(c, make_req(random_op()));
      end
    end
    wait_drain();
    fair_mode = 1'b0;

    @(posedge clk_i);
    bp_mode = 1'b1;
    for (int i = 0; i < N_BP; i++) begin
      for (int c = 0; c < NUM_CHAN; c++) begin
        send_req(c, make_req(random_op()));
      end
    end
    wait_drain();
    @(posedge clk_i);
    bp_mode = 1'b0;

    // Idle tail to catch late duplicates
    repeat (10) @(negedge clk_i);
    if (exp_q[0].size() != 0 || exp_q[1].size() != 0) begin
      report_failure("Expected results were never returned");
    end else begin
      $display("ALL TESTS PASSED");
      $finish;
    end
  end

endmodule
